// File: hw/fetch_pkg.sv
package fetch_pkg;

   // ------------------------------
   // Host opcodes
   // ------------------------------
   typedef enum logic [1:0] {
      OP_NOP       = 2'd0,  // Dropped, credit comes straight back
      OP_FETCH_INC = 2'd1,  // Consecutive addresses
      OP_FETCH_FIX = 2'd2,  // Same address every beat
      OP_BAD       = 2'd3   // Reserved encoding
   } fetch_op_e;

   // ------------------------------
   // Burst master states
   // ------------------------------
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,      // Waiting for a command or a reject
      ST_ISSUE = 2'd1,      // Strobes still to go out
      ST_DRAIN = 2'd2,      // All strobes out, answers pending
      ST_END   = 2'd3       // One cycle to report status
   } fetch_state_e;

   // Completion code, one per non-NOP command
   typedef enum logic [1:0] {
      STAT_OK      = 2'd0,
      STAT_BUS_ERR = 2'd1,  // Slave answered with err
      STAT_REJECT  = 2'd2   // Bad opcode or zero length
   } fetch_status_e;

   // ------------------------------
   // Defaults for the top level
   // ------------------------------
   localparam int DEF_ADDR_W = 16;  // Word address
   localparam int DEF_DATA_W = 32;
   localparam int DEF_LEN_W  = 5;   // Up to 31 words per command
   localparam int DEF_QDEPTH = 4;   // Result buffer slots

endpackage

// File: hw/fetch_cmd_if.sv
// Checked command, decode to execute
interface fetch_cmd_if #(
   parameter int ADDR_W = fetch_pkg::DEF_ADDR_W,
   parameter int LEN_W  = fetch_pkg::DEF_LEN_W
);

   logic              valid;  // Held until taken
   logic              fixed;  // FETCH_FIX, address does not advance
   logic [ADDR_W-1:0] addr;   // Start address
   logic [LEN_W-1:0]  len;    // Never zero here
   logic              taken;  // One-cycle pulse from execute

   // Decode side
   modport src (
      output valid, fixed, addr, len,
      input  taken
   );

   // Execute side
   modport dst (
      input  valid, fixed, addr, len,
      output taken
   );

endinterface

// File: hw/fetch_word_if.sv
// Returned words and slot credits, execute to result
interface fetch_word_if #(
   parameter int DATA_W = fetch_pkg::DEF_DATA_W
);

   logic                     data_valid;    // One per bus answer
   logic [DATA_W-1:0]        data;
   logic                     last;          // Final word of the command
   logic                     err;           // Answer was err_i, no data
   logic                     status_valid;  // Once per command
   fetch_pkg::fetch_status_e status;
   logic                     slot_credit;   // Buffer slot freed

   // Burst master side
   modport src (
      output data_valid, data, last, err, status_valid, status,
      input  slot_credit
   );

   // Result buffer side
   modport dst (
      input  data_valid, data, last, err, status_valid, status,
      output slot_credit
   );

endinterface

// File: hw/fetch_decode.sv
module fetch_decode #(
   parameter int ADDR_W = fetch_pkg::DEF_ADDR_W,
   parameter int LEN_W  = fetch_pkg::DEF_LEN_W
) (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 cmd_valid_i,
   input  fetch_pkg::fetch_op_e cmd_op_i,
   input  logic [ADDR_W-1:0]    cmd_addr_i,
   input  logic [LEN_W-1:0]     cmd_len_i,
   output logic                 cmd_credit_o,
   fetch_cmd_if.src             cmd,
   output logic                 reject_o
);

   logic is_fetch;   // INC or FIX
   logic good;       // Goes into the command register
   logic bad;        // Reported as STAT_REJECT

   // ------------------------------
   // Command check
   // ------------------------------
   assign is_fetch = (cmd_op_i == fetch_pkg::OP_FETCH_INC) ||
                     (cmd_op_i == fetch_pkg::OP_FETCH_FIX);
   assign good     = is_fetch && (cmd_len_i != '0);

   // Zero length on a fetch, or the reserved opcode
   assign bad      = (cmd_op_i == fetch_pkg::OP_BAD) ||
                     (is_fetch && (cmd_len_i == '0));

   // ------------------------------
   // Control: slot, credit, reject
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cmd.valid    <= 1'b0;
         cmd_credit_o <= 1'b0;
         reject_o     <= 1'b0;
      end else begin
         if (cmd_valid_i && good)
            cmd.valid <= 1'b1;  // Slot filled
         else if (cmd.taken)
            cmd.valid <= 1'b0;  // Execute has it now

         // Slot is free again at once for NOP and rejects
         cmd_credit_o <= (cmd_valid_i && !good) || cmd.taken;
         reject_o     <= cmd_valid_i && bad;   // Single-cycle pulse
      end
   end

   // Payload, loaded only on an accepted command
   always_ff @(posedge clk_i) begin
      if (cmd_valid_i && good) begin
         cmd.fixed <= (cmd_op_i == fetch_pkg::OP_FETCH_FIX);
         cmd.addr  <= cmd_addr_i;
         cmd.len   <= cmd_len_i;
      end
   end

endmodule

// File: hw/wb_burst_fetch.sv
module wb_burst_fetch #(
   parameter int ADDR_W = fetch_pkg::DEF_ADDR_W,
   parameter int DATA_W = fetch_pkg::DEF_DATA_W,
   parameter int LEN_W  = fetch_pkg::DEF_LEN_W,
   parameter int QDEPTH = fetch_pkg::DEF_QDEPTH
) (
   input  logic              clk_i,
   input  logic              rst_i,
   fetch_cmd_if.dst          cmd,
   input  logic              reject_i,
   output logic              cyc_o,
   output logic              stb_o,
   output logic [ADDR_W-1:0] adr_o,
   input  logic [DATA_W-1:0] dat_i,
   input  logic              ack_i,
   input  logic              stall_i,
   input  logic              err_i,
   fetch_word_if.src         word
);

   localparam int CNT_W = $clog2(QDEPTH + 1);  // Holds 0..QDEPTH
   localparam int REJ_W = 8;

   fetch_pkg::fetch_state_e  state;
   fetch_pkg::fetch_status_e end_stat;      // Reported in ST_END
   logic [CNT_W-1:0]         credits;       // Free result slots not yet spent
   logic [CNT_W-1:0]         credits_nxt;
   logic [CNT_W-1:0]         pending;       // Accepted strobes awaiting an answer
   logic [CNT_W-1:0]         pending_nxt;
   logic [LEN_W-1:0]         remain;        // Strobes still to be accepted
   logic [LEN_W-1:0]         remain_nxt;
   logic                     fixed;
   logic [REJ_W-1:0]         rej_cnt;       // Rejects queued while a burst runs
   logic                     accept;        // Strobe taken by the slave
   logic                     answer;        // ack or err this cycle
   logic                     final_ack;
   logic                     drained;       // Result buffer empty
   logic                     take;
   logic                     serve_rej;

   // ------------------------------
   // Bus handshake and counters
   // ------------------------------
   assign accept      = stb_o && !stall_i;
   assign answer      = cyc_o && (ack_i || err_i);
   assign remain_nxt  = remain - LEN_W'(accept);
   assign pending_nxt = pending + CNT_W'(accept) - CNT_W'(answer);
   assign final_ack   = cyc_o && ack_i && !err_i && (remain_nxt == '0) && (pending_nxt == '0);

   // On err the in-flight strobes never reach the buffer, so their credits come back here
   assign credits_nxt = (cyc_o && err_i) ?
                        credits + pending + CNT_W'(word.slot_credit) :
                        credits - CNT_W'(accept) + CNT_W'(word.slot_credit);

   // New work only once the previous command has fully left the buffer
   assign drained   = (credits == CNT_W'(QDEPTH));
   assign serve_rej = (state == fetch_pkg::ST_IDLE) && drained && (rej_cnt != '0);
   assign take      = (state == fetch_pkg::ST_IDLE) && drained && (rej_cnt == '0) && cmd.valid;
   assign cmd.taken = take;

   // Answers forwarded as they come, in order
   assign word.data_valid   = answer;
   assign word.data         = dat_i;
   assign word.err          = err_i;
   assign word.last         = final_ack;
   assign word.status_valid = (state == fetch_pkg::ST_END);
   assign word.status       = end_stat;

   // ------------------------------
   // Burst FSM
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state   <= fetch_pkg::ST_IDLE;
         cyc_o   <= 1'b0;
         stb_o   <= 1'b0;
         credits <= CNT_W'(QDEPTH);
         pending <= '0;
         rej_cnt <= '0;
      end else begin
         credits <= credits_nxt;
         rej_cnt <= rej_cnt + REJ_W'(reject_i) - REJ_W'(serve_rej);
         case (state)
            fetch_pkg::ST_IDLE: begin
               pending <= '0;
               if (serve_rej) begin
                  end_stat <= fetch_pkg::STAT_REJECT;
                  state    <= fetch_pkg::ST_END;
               end else if (take) begin
                  cyc_o  <= 1'b1;
                  stb_o  <= 1'b1;           // Full credit, first strobe goes out
                  adr_o  <= cmd.addr;
                  remain <= cmd.len;
                  fixed  <= cmd.fixed;
                  state  <= fetch_pkg::ST_ISSUE;
               end
            end
            fetch_pkg::ST_ISSUE, fetch_pkg::ST_DRAIN: begin
               remain  <= remain_nxt;
               pending <= pending_nxt;
               if (accept && !fixed)
                  adr_o <= adr_o + 1'b1;
               if (err_i) begin             // Abort, late answers dropped
                  cyc_o    <= 1'b0;
                  stb_o    <= 1'b0;
                  pending  <= '0;
                  end_stat <= fetch_pkg::STAT_BUS_ERR;
                  state    <= fetch_pkg::ST_END;
               end else if (final_ack) begin
                  cyc_o    <= 1'b0;
                  stb_o    <= 1'b0;
                  end_stat <= fetch_pkg::STAT_OK;
                  state    <= fetch_pkg::ST_END;
               end else begin
                  // Pause strobing when out of slots
                  stb_o <= (remain_nxt != '0) && (credits_nxt != '0);
                  state <= (remain_nxt == '0) ? fetch_pkg::ST_DRAIN : fetch_pkg::ST_ISSUE;
               end
            end
            fetch_pkg::ST_END: state <= fetch_pkg::ST_IDLE;
            default:           state <= fetch_pkg::ST_IDLE;
         endcase
      end
   end

endmodule

// File: hw/fetch_result.sv
module fetch_result #(
   parameter int DATA_W = fetch_pkg::DEF_DATA_W,
   parameter int QDEPTH = fetch_pkg::DEF_QDEPTH
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   fetch_word_if.dst                word,
   output logic                     out_valid_o,
   output logic [DATA_W-1:0]        out_data_o,
   output logic                     out_last_o,
   input  logic                     out_credit_i,
   output logic                     done_o,
   output fetch_pkg::fetch_status_e done_status_o
);

   localparam int PTR_W   = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
   localparam int CNT_W   = $clog2(QDEPTH + 1);
   localparam int OCRED_W = 8;   // Saturates, extra grants are dropped

   logic [DATA_W:0]          mem [QDEPTH];  // {last, data}
   logic [PTR_W-1:0]         wr_ptr;
   logic [PTR_W-1:0]         rd_ptr;
   logic [CNT_W-1:0]         count;         // Words held
   logic [OCRED_W-1:0]       ocred;         // Consumer credits held
   logic                     wr;
   logic                     send;
   logic                     grant;
   logic                     finish;
   logic                     stat_pend;     // Status waiting for buffer to empty
   fetch_pkg::fetch_status_e stat_hold;

   assign wr     = word.data_valid && !word.err;  // err answers carry no data
   assign send   = (count != '0) && (ocred != '0);
   assign grant  = out_credit_i && (ocred != '1);
   assign finish = (stat_pend || word.status_valid) && (count == '0);

   assign word.slot_credit = send;  // Slot frees as the word leaves

   // ------------------------------
   // Buffer storage and output word
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (wr)
         mem[wr_ptr] <= {word.last, word.data};
      if (send)
         {out_last_o, out_data_o} <= mem[rd_ptr];
      if (word.status_valid)
         stat_hold <= word.status;
      if (finish)
         done_status_o <= word.status_valid ? word.status : stat_hold;
   end

   // ------------------------------
   // Pointers, counters, done
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         ocred       <= '0;
         out_valid_o <= 1'b0;
         done_o      <= 1'b0;
         stat_pend   <= 1'b0;
      end else begin
         if (wr)
            wr_ptr <= (wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (send)
            rd_ptr <= (rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count       <= count + CNT_W'(wr) - CNT_W'(send);
         ocred       <= ocred + OCRED_W'(grant) - OCRED_W'(send);
         out_valid_o <= send;
         done_o      <= finish;   // Cycle after the last word shows
         if (finish)
            stat_pend <= 1'b0;
         else if (word.status_valid)
            stat_pend <= 1'b1;
      end
   end

endmodule

// File: hw/block_fetch_top.sv
module block_fetch_top #(
   parameter int ADDR_W = fetch_pkg::DEF_ADDR_W,
   parameter int DATA_W = fetch_pkg::DEF_DATA_W,
   parameter int LEN_W  = fetch_pkg::DEF_LEN_W,
   parameter int QDEPTH = fetch_pkg::DEF_QDEPTH
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   // Host commands
   input  logic                     cmd_valid_i,
   input  fetch_pkg::fetch_op_e     cmd_op_i,
   input  logic [ADDR_W-1:0]        cmd_addr_i,
   input  logic [LEN_W-1:0]         cmd_len_i,
   output logic                     cmd_credit_o,
   // Wishbone pipelined master, read only
   output logic                     cyc_o,
   output logic                     stb_o,
   output logic [ADDR_W-1:0]        adr_o,
   input  logic [DATA_W-1:0]        dat_i,
   input  logic                     ack_i,
   input  logic                     stall_i,
   input  logic                     err_i,
   // Word stream
   output logic                     out_valid_o,
   output logic [DATA_W-1:0]        out_data_o,
   output logic                     out_last_o,
   input  logic                     out_credit_i,
   // Completion
   output logic                     done_o,
   output fetch_pkg::fetch_status_e done_status_o
);

   logic reject;  // Decode to execute

   // ------------------------------
   // Internal links
   // ------------------------------
   fetch_cmd_if #(.ADDR_W(ADDR_W), .LEN_W(LEN_W)) cmd_link ();
   fetch_word_if #(.DATA_W(DATA_W))               word_link ();

   fetch_decode #(.ADDR_W(ADDR_W), .LEN_W(LEN_W)) u_decode (
      .clk_i, .rst_i, .cmd_valid_i, .cmd_op_i, .cmd_addr_i, .cmd_len_i,
      .cmd_credit_o, .cmd(cmd_link), .reject_o(reject)
   );

   wb_burst_fetch #(
      .ADDR_W(ADDR_W), .DATA_W(DATA_W), .LEN_W(LEN_W), .QDEPTH(QDEPTH)
   ) u_execute (
      .clk_i, .rst_i, .cmd(cmd_link), .reject_i(reject),
      .cyc_o, .stb_o, .adr_o, .dat_i, .ack_i, .stall_i, .err_i, .word(word_link)
   );

   fetch_result #(.DATA_W(DATA_W), .QDEPTH(QDEPTH)) u_result (
      .clk_i, .rst_i, .word(word_link), .out_valid_o, .out_data_o, .out_last_o,
      .out_credit_i, .done_o, .done_status_o
   );

endmodule

// File: tests/wb_mem_model.sv
module wb_mem_model (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic [15:0] adr_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        stall_o,
   output logic        err_o
);
   timeunit 1ns;
   timeprecision 100ps;

   integer      seed = 26693;   // Stall and delay draws
   logic [15:0] addr_q [$];     // Accepted but not answered yet
   int          wait_q [$];     // Extra cycles before each answer

   initial begin
      {dat_o, ack_o, stall_o, err_o} = '0;
   end

   // ------------------------------
   // Pipelined slave answering in order
   // ------------------------------
   always @(posedge clk_i) begin : serve
      logic [15:0] a;
      logic        ack_n;
      logic        err_n;
      int          w;
      a     = '0;
      ack_n = 1'b0;
      err_n = 1'b0;
      if (rst_i || !cyc_i) begin
         addr_q.delete();   // Dropped cycle ends all requests
         wait_q.delete();
      end else begin
         if (addr_q.size() != 0) begin
            w = wait_q.pop_front();
            if (w != 0) begin
               wait_q.push_front(w - 1);   // Head still delayed
            end else begin
               a     = addr_q.pop_front();
               err_n = (a >= 16'hF000);     // Error region
               ack_n = !err_n;
            end
         end
         if (stb_i && !stall_o) begin
            addr_q.push_back(adr_i);
            wait_q.push_back({$random(seed)} % 3);   // 0 to 2 cycles
         end
      end
      // Outputs move a little after the edge
      ack_o   <= #5 ack_n;
      err_o   <= #5 err_n;
      dat_o   <= #5 {16'h0000, a} ^ 32'hA5A5_0000;
      stall_o <= #5 (({$random(seed)} % 4) == 0);   // Stall about one cycle in four
   end

endmodule

// File: tests/tb_block_fetch.sv
module tb_block_fetch;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NROWS   = 9;
   localparam int TIMEOUT = 500;   // Cycles without progress

   typedef struct packed {
      fetch_pkg::fetch_op_e     op;
      logic [15:0]              addr;
      logic [4:0]               len;
      logic                     slow;   // One consumer credit per 6 cycles
      fetch_pkg::fetch_status_e stat;
   } row_t;

   row_t                     rows [NROWS];
   logic                     clk_i = 1'b0;
   logic                     rst_i, cmd_valid_i, cmd_credit_o;
   fetch_pkg::fetch_op_e     cmd_op_i;
   logic [15:0]              cmd_addr_i, adr_o;
   logic [4:0]               cmd_len_i;
   logic                     cyc_o, stb_o, ack_i, stall_i, err_i;
   logic [31:0]              dat_i, out_data_o;
   logic                     out_valid_o, out_last_o, out_credit_i, done_o;
   fetch_pkg::fetch_status_e done_status_o;
   int                       cred_granted;   // Consumer credits given so far
   int                       words_seen;     // Words taken from the stream

   always #20 clk_i = ~clk_i;

   block_fetch_top UUT (.*);

   wb_mem_model mem (
      .clk_i, .rst_i, .cyc_i(cyc_o), .stb_i(stb_o), .adr_i(adr_o),
      .dat_o(dat_i), .ack_o(ack_i), .stall_o(stall_i), .err_o(err_i)
   );

   task automatic abort_run;
      $display("Done: errors found");
      $fatal(1, "simulation stopped at the first failing check");
   endtask

   // Words expected before the error region, none for rejects and NOP
   function automatic int word_count(row_t r);
      int n;
      n = 0;
      if (r.op == fetch_pkg::OP_FETCH_INC || r.op == fetch_pkg::OP_FETCH_FIX)
         while (n < r.len &&
                16'(r.addr + ((r.op == fetch_pkg::OP_FETCH_INC) ? n : 0)) < 16'hF000)
            n++;
      return n;
   endfunction

   // ------------------------------
   // Host, sends only on a held credit
   // ------------------------------
   task automatic send_commands;
      int sent;
      int held;
      int idle;
      sent = 0;
      held = 1;   // One command slot
      idle = 0;
      while (sent < NROWS || held == 0) begin
         @(posedge clk_i);
         #5;
         cmd_valid_i = 1'b0;
         if (cmd_credit_o)
            held++;
         if (held > 0 && sent < NROWS) begin
            cmd_valid_i = 1'b1;
            cmd_op_i    = rows[sent].op;
            cmd_addr_i  = rows[sent].addr;
            cmd_len_i   = rows[sent].len;
            held--;
            sent++;
            idle = 0;
         end else begin
            idle++;
            assert (idle < TIMEOUT) else begin
               $display("no command credit came back in time");
               abort_run();
            end
         end
      end
   endtask

   // ------------------------------
   // Consumer and checker for one row
   // ------------------------------
   task automatic check_row(int r);
      row_t        x;
      logic [15:0] a;
      logic        done_seen;
      int          n, nexp, granted, k, idle;
      x         = rows[r];
      nexp      = word_count(x);
      done_seen = 1'b0;
      {n, granted, k, idle} = '0;
      while (!done_seen) begin
         @(posedge clk_i);
         #5;   // Outputs settled, inputs change here
         out_credit_i = 1'b0;
         if (out_valid_o) begin
            words_seen++;
            a = (x.op == fetch_pkg::OP_FETCH_FIX) ? x.addr : 16'(x.addr + n);
            assert (words_seen <= cred_granted) else begin
               $display("a word left without a consumer credit");
               abort_run();
            end
            assert (n < nexp) else begin
               $display("row %0d sent more than %0d words", r, nexp);
               abort_run();
            end
            assert (out_data_o == ({16'h0000, a} ^ 32'hA5A5_0000)) else begin
               $display("error: out_data_o = %h, expected %h", out_data_o,
                        {16'h0000, a} ^ 32'hA5A5_0000);
               abort_run();
            end
            if (x.stat == fetch_pkg::STAT_OK) begin
               assert (out_last_o == (n == nexp - 1)) else begin
                  $display("error: out_last_o = %h, expected %h", out_last_o, n == nexp - 1);
                  abort_run();
               end
            end
            n++;
            idle = 0;
         end
         if (done_o) begin
            assert (n == nexp) else begin
               $display("row %0d finished after %0d of %0d words", r, n, nexp);
               abort_run();
            end
            assert (done_status_o == x.stat) else begin
               $display("error: done_status_o = %h, expected %h", done_status_o, x.stat);
               abort_run();
            end
            done_seen = 1'b1;
         end
         if (granted < nexp && (!x.slow || k % 6 == 0)) begin
            out_credit_i = 1'b1;   // Grant only what this row needs
            granted++;
            cred_granted++;
         end
         k++;
         idle++;
         assert (idle < TIMEOUT) else begin
            $display("row %0d did not complete in time", r);
            abort_run();
         end
      end
      out_credit_i = 1'b0;
   endtask

   initial begin : main
      int r;
      rows[0] = '{fetch_pkg::OP_FETCH_INC, 16'h0100, 5'd9,  1'b0, fetch_pkg::STAT_OK};
      rows[1] = '{fetch_pkg::OP_FETCH_FIX, 16'h0040, 5'd5,  1'b0, fetch_pkg::STAT_OK};
      rows[2] = '{fetch_pkg::OP_FETCH_INC, 16'h0300, 5'd31, 1'b1, fetch_pkg::STAT_OK};
      rows[3] = '{fetch_pkg::OP_FETCH_INC, 16'hEFFE, 5'd6,  1'b0, fetch_pkg::STAT_BUS_ERR};
      rows[4] = '{fetch_pkg::OP_FETCH_INC, 16'h0010, 5'd0,  1'b0, fetch_pkg::STAT_REJECT};
      rows[5] = '{fetch_pkg::OP_BAD,       16'h0020, 5'd3,  1'b0, fetch_pkg::STAT_REJECT};
      rows[6] = '{fetch_pkg::OP_NOP,       16'h0000, 5'd2,  1'b0, fetch_pkg::STAT_OK};
      rows[7] = '{fetch_pkg::OP_FETCH_FIX, 16'h0123, 5'd3,  1'b0, fetch_pkg::STAT_OK};
      rows[8] = '{fetch_pkg::OP_FETCH_INC, 16'h0400, 5'd4,  1'b1, fetch_pkg::STAT_OK};
      rst_i        = 1'b1;
      cmd_valid_i  = 1'b0;
      cmd_op_i     = fetch_pkg::OP_NOP;
      cmd_addr_i   = '0;
      cmd_len_i    = '0;
      out_credit_i = 1'b0;
      cred_granted = 0;
      words_seen   = 0;
      repeat (5) @(posedge clk_i);
      #5;
      rst_i = 1'b0;
      assert ({cyc_o, stb_o, out_valid_o, done_o, cmd_credit_o} == '0) else begin
         $display("error: reset outputs = %h, expected 00",
                  {cyc_o, stb_o, out_valid_o, done_o, cmd_credit_o});
         abort_run();
      end
      // Commands go back to back while results are checked in order
      fork
         send_commands();
         for (r = 0; r < NROWS; r++)
            if (rows[r].op != fetch_pkg::OP_NOP)
               check_row(r);
      join
      repeat (20) begin   // Nothing more may come out
         @(posedge clk_i);
         #5;
         assert (!out_valid_o && !done_o) else begin
            $display("output appeared after the last command finished");
            abort_run();
         end
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

// File: filelist.f
hw/fetch_pkg.sv
hw/fetch_cmd_if.sv
hw/fetch_word_if.sv
hw/fetch_decode.sv
hw/wb_burst_fetch.sv
hw/fetch_result.sv
hw/block_fetch_top.sv
tests/wb_mem_model.sv
tests/tb_block_fetch.sv
